// File: coleco_ctrl_macros.svh
`ifndef COLECO_CTRL_MACROS_SVH
`define COLECO_CTRL_MACROS_SVH

// ============================================================
// Controller input widths and counts
// ============================================================

// Host joystick word, one per player
`define JOY_W 32

// Console controller ports
`define NUM_PORTS 2

// Host PS/2 event, toggle + pressed + extended + scan code
`define PS2_W 11

// Keypad code on the four port data lines
`define KEY_CODE_W 4

// Buttons of one pad
// 10 digits, star, number, purple, blue, four directions, two fires
`define PAD_BTN_W 20

`endif

// File: coleco_ctrl_pkg.sv
`default_nettype none

`include "coleco_ctrl_macros.svh"

package coleco_ctrl_pkg;

        // ============================================================
        // Keypad codes as seen on the port data lines
        // ============================================================
        typedef enum logic [`KEY_CODE_W-1:0] {
                KEY_0      = 4'b0011,
                KEY_1      = 4'b1110,
                KEY_2      = 4'b1101,
                KEY_3      = 4'b0110,
                KEY_4      = 4'b0001,
                KEY_5      = 4'b1001,
                KEY_6      = 4'b0111,
                KEY_7      = 4'b1100,
                KEY_8      = 4'b1000,
                KEY_9      = 4'b1011,
                KEY_STAR   = 4'b1010,
                KEY_NUMBER = 4'b0101,
                KEY_PURPLE = 4'b0100,
                KEY_BLUE   = 4'b0010,
                KEY_NONE   = 4'b1111
        } key_code_e;

        // Set-2 scan codes used by the keypad emulation
        typedef enum logic [7:0] {
                SC_TOP_0    = 8'h45,
                SC_TOP_1    = 8'h16,
                SC_TOP_2    = 8'h1E,
                SC_TOP_3    = 8'h26,
                SC_TOP_4    = 8'h25,
                SC_TOP_5    = 8'h2E,
                SC_TOP_6    = 8'h36,
                SC_TOP_7    = 8'h3D,
                SC_TOP_8    = 8'h3E,
                SC_TOP_9    = 8'h46,
                SC_KP_0     = 8'h70,
                SC_KP_1     = 8'h69,
                SC_KP_2     = 8'h72,
                SC_KP_3     = 8'h7A,
                SC_KP_4     = 8'h6B,
                SC_KP_5     = 8'h73,
                SC_KP_6     = 8'h74,
                SC_KP_7     = 8'h6C,
                SC_KP_8     = 8'h75,
                SC_KP_9     = 8'h7D,
                SC_KP_STAR  = 8'h7C,
                SC_KP_MINUS = 8'h7B,
                SC_LSHIFT   = 8'h12,
                SC_RSHIFT   = 8'h59
        } ps2_scan_e;

        // Toggle flips once per new key event
        typedef struct packed {
                logic                 toggle;
                logic                 pressed;
                logic                 extended;
                logic [`PS2_W-4:0]    scan;
        } ps2_event_t;

        // One pad, all buttons active high
        typedef struct packed {
                logic [9:0] digit;
                logic       star;
                logic       number;
                logic       purple;
                logic       blue;
                logic       up;
                logic       down;
                logic       left;
                logic       right;
                logic       fire1;
                logic       fire2;
        } pad_buttons_t;

        // Segment strobes from the console, active low
        typedef struct packed {
                logic keypad_sel_n;
                logic joy_sel_n;
        } ctrl_sel_t;

        // Port lines back to the console, active low
        typedef struct packed {
                logic [`KEY_CODE_W-1:0] lines;
                logic                   fire_n;
        } ctrl_port_t;

endpackage

`default_nettype wire

// File: ps2_keypad_emu.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_keypad_emu (
        input  logic                          clk_sys,
        input  logic                          arst_n_i,
        input  coleco_ctrl_pkg::ps2_event_t   ps2_key_i,
        output coleco_ctrl_pkg::pad_buttons_t kbd_buttons_o
);

        coleco_ctrl_pkg::ps2_scan_e scan;
        logic                       pressed;
        logic                       toggle_q;
        logic                       new_event;
        logic [9:0]                 digit_q;
        logic                       star_q;
        logic                       minus_q;
        logic                       shift_q;

        assign scan      = coleco_ctrl_pkg::ps2_scan_e'(ps2_key_i.scan);
        assign pressed   = ps2_key_i.pressed;
        assign new_event = ps2_key_i.toggle != toggle_q;

        // ============================================================
        // Event detection
        // ============================================================
        always_ff @(posedge clk_sys or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        toggle_q <= 1'b0;
                end else begin
                        toggle_q <= ps2_key_i.toggle;
                end
        end

        // ============================================================
        // Button latches, make sets and break clears
        // ============================================================
        always_ff @(posedge clk_sys or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        digit_q <= '0;
                        star_q  <= 1'b0;
                        minus_q <= 1'b0;
                        shift_q <= 1'b0;
                end else if (new_event) begin
                        // Extended prefix does not matter here
                        case (scan)
                                coleco_ctrl_pkg::SC_TOP_0, coleco_ctrl_pkg::SC_KP_0:
                                        digit_q[0] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_1, coleco_ctrl_pkg::SC_KP_1:
                                        digit_q[1] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_2, coleco_ctrl_pkg::SC_KP_2:
                                        digit_q[2] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_3, coleco_ctrl_pkg::SC_KP_3:
                                        digit_q[3] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_4, coleco_ctrl_pkg::SC_KP_4:
                                        digit_q[4] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_5, coleco_ctrl_pkg::SC_KP_5:
                                        digit_q[5] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_6, coleco_ctrl_pkg::SC_KP_6:
                                        digit_q[6] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_7, coleco_ctrl_pkg::SC_KP_7:
                                        digit_q[7] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_8, coleco_ctrl_pkg::SC_KP_8:
                                        digit_q[8] <= pressed;
                                coleco_ctrl_pkg::SC_TOP_9, coleco_ctrl_pkg::SC_KP_9:
                                        digit_q[9] <= pressed;
                                coleco_ctrl_pkg::SC_KP_STAR:
                                        star_q <= pressed;
                                // Keypad minus stands in for the number key
                                coleco_ctrl_pkg::SC_KP_MINUS:
                                        minus_q <= pressed;
                                // Both shift keys share one latch
                                coleco_ctrl_pkg::SC_LSHIFT, coleco_ctrl_pkg::SC_RSHIFT:
                                        shift_q <= pressed;
                                default: ;
                        endcase
                end
        end

        // ============================================================
        // Emulated pad
        // ============================================================
        always_comb begin
                kbd_buttons_o        = '0;
                kbd_buttons_o.digit  = digit_q;
                // Shift+8 is '*' and shift+3 is '#' on a PC keyboard
                kbd_buttons_o.star   = star_q | (shift_q & digit_q[8]);
                kbd_buttons_o.number = minus_q | (shift_q & digit_q[3]);
        end

        // Toggle must be clean once out of reset, else events are lost or doubled
        toggle_known_a: assert property (
                @(posedge clk_sys) disable iff (!arst_n_i)
                !$isunknown(ps2_key_i.toggle)
        ) else $error("ps2 toggle is unknown");

endmodule

`default_nettype wire

// File: keypad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "coleco_ctrl_macros.svh"

module keypad_encoder (
        input  coleco_ctrl_pkg::pad_buttons_t pad_i,
        input  coleco_ctrl_pkg::ctrl_sel_t    sel_i,
        output coleco_ctrl_pkg::ctrl_port_t   port_o
);

        logic [13:0]                keys;
        coleco_ctrl_pkg::key_code_e key_code;
        logic [`KEY_CODE_W-1:0]     key_lines;
        logic [`KEY_CODE_W-1:0]     joy_lines;
        logic                       key_fire_n;
        logic                       joy_fire_n;

        // Bit 0 has the highest priority
        assign keys = {pad_i.blue, pad_i.purple, pad_i.number, pad_i.star, pad_i.digit};

        // ============================================================
        // Keypad priority encoder
        // ============================================================
        always_comb begin
                casez (keys)
                        14'b?????????????1: key_code = coleco_ctrl_pkg::KEY_0;
                        14'b????????????10: key_code = coleco_ctrl_pkg::KEY_1;
                        14'b???????????100: key_code = coleco_ctrl_pkg::KEY_2;
                        14'b??????????1000: key_code = coleco_ctrl_pkg::KEY_3;
                        14'b?????????10000: key_code = coleco_ctrl_pkg::KEY_4;
                        14'b????????100000: key_code = coleco_ctrl_pkg::KEY_5;
                        14'b???????1000000: key_code = coleco_ctrl_pkg::KEY_6;
                        14'b??????10000000: key_code = coleco_ctrl_pkg::KEY_7;
                        14'b?????100000000: key_code = coleco_ctrl_pkg::KEY_8;
                        14'b????1000000000: key_code = coleco_ctrl_pkg::KEY_9;
                        14'b???10000000000: key_code = coleco_ctrl_pkg::KEY_STAR;
                        14'b??100000000000: key_code = coleco_ctrl_pkg::KEY_NUMBER;
                        14'b?1000000000000: key_code = coleco_ctrl_pkg::KEY_PURPLE;
                        14'b10000000000000: key_code = coleco_ctrl_pkg::KEY_BLUE;
                        default:            key_code = coleco_ctrl_pkg::KEY_NONE;
                endcase
        end

        // Keypad segment, fire line carries button 2
        assign key_lines  = sel_i.keypad_sel_n ? '1 : key_code;
        assign key_fire_n = sel_i.keypad_sel_n | ~pad_i.fire2;

        // ============================================================
        // Joystick segment
        // ============================================================
        // Up on the top line, right on the bottom one
        assign joy_lines  = sel_i.joy_sel_n ? '1
                                            : ~{pad_i.up, pad_i.down, pad_i.left, pad_i.right};
        assign joy_fire_n = sel_i.joy_sel_n | ~pad_i.fire1;

        // Open-drain style merge when both strobes are low
        assign port_o.lines  = key_lines & joy_lines;
        assign port_o.fire_n = key_fire_n & joy_fire_n;

        // Port is released whenever the console selects neither segment
        always_comb begin
                if (sel_i.keypad_sel_n && sel_i.joy_sel_n) begin
                        idle_port_a: assert final (port_o == '1)
                                else $error("port driven with both strobes high");
                end
        end

endmodule

`default_nettype wire

// File: controller_ports.sv
`timescale 1ns/1ps
`default_nettype none

`include "coleco_ctrl_macros.svh"

module controller_ports (
        input  logic [`JOY_W-1:0]                             joy_a_i,
        input  logic [`JOY_W-1:0]                             joy_b_i,
        input  logic                                          swap_i,
        input  coleco_ctrl_pkg::pad_buttons_t                 kbd_buttons_i,
        input  coleco_ctrl_pkg::ctrl_sel_t  [`NUM_PORTS-1:0]  sel_i,
        output coleco_ctrl_pkg::ctrl_port_t [`NUM_PORTS-1:0]  ctrl_o
);

        logic [`JOY_W-1:0] joy_word [`NUM_PORTS];

        // ============================================================
        // Host joystick word to pad buttons
        // ============================================================
        // Host layout
        //   0..3   right, left, down, up
        //   4, 5   fire 1, fire 2
        //   6, 7   star, number
        //   8..17  digits 0 to 9
        //   18, 19 purple, blue
        function automatic coleco_ctrl_pkg::pad_buttons_t map_joy(
                input logic [`JOY_W-1:0] joy
        );
                logic [`PAD_BTN_W-1:0] raw;

                raw = {joy[17:8],
                       joy[6], joy[7],
                       joy[18], joy[19],
                       joy[3], joy[2], joy[1], joy[0],
                       joy[4], joy[5]};
                return coleco_ctrl_pkg::pad_buttons_t'(raw);
        endfunction

        // Player swap
        assign joy_word[0] = swap_i ? joy_b_i : joy_a_i;
        assign joy_word[1] = swap_i ? joy_a_i : joy_b_i;

        // ============================================================
        // One encoder per console port
        // ============================================================
        for (genvar p = 0; p < `NUM_PORTS; p++) begin : g_port
                coleco_ctrl_pkg::pad_buttons_t pad;

                // Keyboard pad shows up on every port
                assign pad = coleco_ctrl_pkg::pad_buttons_t'(map_joy(joy_word[p])
                                                             | kbd_buttons_i);

                keypad_encoder u_enc (
                        .pad_i  (pad),
                        .sel_i  (sel_i[p]),
                        .port_o (ctrl_o[p])
                );
        end

endmodule

`default_nettype wire

// File: coleco_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "coleco_ctrl_macros.svh"

module coleco_ctrl_top (
        input  logic                                          clk_sys,
        input  logic                                          arst_n_i,
        input  coleco_ctrl_pkg::ps2_event_t                   ps2_key_i,
        input  logic [`JOY_W-1:0]                             joy_a_i,
        input  logic [`JOY_W-1:0]                             joy_b_i,
        input  logic                                          swap_i,
        input  coleco_ctrl_pkg::ctrl_sel_t  [`NUM_PORTS-1:0]  sel_i,
        output coleco_ctrl_pkg::ctrl_port_t [`NUM_PORTS-1:0]  ctrl_o
);

        // Keypad buttons emulated from the PS/2 keyboard
        coleco_ctrl_pkg::pad_buttons_t kbd_buttons;

        // ============================================================
        // Keyboard side
        // ============================================================
        ps2_keypad_emu u_kbd (
                .clk_sys       (clk_sys),
                .arst_n_i      (arst_n_i),
                .ps2_key_i     (ps2_key_i),
                .kbd_buttons_o (kbd_buttons)
        );

        // ============================================================
        // Console ports, combinational from joysticks and strobes
        // ============================================================
        controller_ports u_ports (
                .joy_a_i       (joy_a_i),
                .joy_b_i       (joy_b_i),
                .swap_i        (swap_i),
                .kbd_buttons_i (kbd_buttons),
                .sel_i         (sel_i),
                .ctrl_o        (ctrl_o)
        );

endmodule

`default_nettype wire

// File: tb_coleco_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "coleco_ctrl_macros.svh"

module tb_coleco_ctrl;

        localparam int RESET_CYCLES = 10;
        localparam int N_PAD        = 40;
        localparam int N_BOTH       = 20;
        localparam int N_SWAP       = 20;
        localparam int N_KEY_EVENTS = 16;
        localparam int N_MIX        = 300;
        localparam int TEST_CYCLES  = 16 + 14 + 1 + N_PAD + 5 + N_BOTH + N_SWAP
                                      + 2 * N_KEY_EVENTS + 1 + N_MIX + 1;
        localparam int MARGIN       = 50;

        // Port line codes, index 0..9 digits then star, number, purple, blue
        localparam logic [3:0] KEY_TABLE [14] = '{
                4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001,
                4'b1001, 4'b0111, 4'b1100, 4'b1000, 4'b1011,
                4'b1010, 4'b0101, 4'b0100, 4'b0010
        };
        // Host joystick bit of each keypad button, same order
        localparam int BTN_BIT [14] = '{8, 9, 10, 11, 12, 13, 14, 15, 16, 17, 6, 7, 18, 19};

        // Set-2 scan codes, top row and numpad digits 0..9
        localparam logic [7:0] SCAN_TOP [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
                                                 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46};
        localparam logic [7:0] SCAN_KP  [10] = '{8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B,
                                                 8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D};
        // Star, minus, shifts and one key the pad ignores
        localparam logic [7:0] SCAN_EXTRA [5] = '{8'h7C, 8'h7B, 8'h12, 8'h59, 8'h1C};

        logic                                         clk_sys;
        logic                                         arst_n_i;
        coleco_ctrl_pkg::ps2_event_t                  ps2_key;
        logic [`JOY_W-1:0]                            joy_a;
        logic [`JOY_W-1:0]                            joy_b;
        logic                                         swap;
        coleco_ctrl_pkg::ctrl_sel_t  [`NUM_PORTS-1:0] sel;
        coleco_ctrl_pkg::ctrl_port_t [`NUM_PORTS-1:0] ctrl_o;

        // Keyboard latches of the model, pending and as seen after the edge
        logic [9:0] digit_p, digit_q;
        logic       star_p, star_q;
        logic       minus_p, minus_q;
        logic       shift_p, shift_q;

        coleco_ctrl_pkg::pad_buttons_t                kbd_model;
        coleco_ctrl_pkg::pad_buttons_t                pad_model [`NUM_PORTS];
        coleco_ctrl_pkg::ctrl_port_t [`NUM_PORTS-1:0] expected_ctrl;

        coleco_ctrl_top dut0 (
                .clk_sys   (clk_sys),
                .arst_n_i  (arst_n_i),
                .ps2_key_i (ps2_key),
                .joy_a_i   (joy_a),
                .joy_b_i   (joy_b),
                .swap_i    (swap),
                .sel_i     (sel),
                .ctrl_o    (ctrl_o)
        );

        always #5 clk_sys = ~clk_sys;

        // ============================================================
        // Reference model
        // ============================================================
        function automatic coleco_ctrl_pkg::pad_buttons_t joy_to_pad(input logic [31:0] j);
                coleco_ctrl_pkg::pad_buttons_t p;
                int                            d;

                p = '0;
                for (d = 0; d < 10; d++) begin
                        p.digit[d] = j[8 + d];
                end
                p.star   = j[6];
                p.number = j[7];
                p.purple = j[18];
                p.blue   = j[19];
                p.up     = j[3];
                p.down   = j[2];
                p.left   = j[1];
                p.right  = j[0];
                p.fire1  = j[4];
                p.fire2  = j[5];
                return p;
        endfunction

        function automatic coleco_ctrl_pkg::ctrl_port_t port_model(
                input coleco_ctrl_pkg::pad_buttons_t p,
                input coleco_ctrl_pkg::ctrl_sel_t    s
        );
                logic [13:0] keys;
                logic [3:0]  kcode;
                logic [3:0]  klines;
                logic [3:0]  jlines;
                logic        kfire;
                logic        jfire;
                int          i;

                keys  = {p.blue, p.purple, p.number, p.star, p.digit};
                kcode = 4'b1111;
                // Walk down so the lowest pressed index is written last
                for (i = 13; i >= 0; i--) begin
                        if (keys[i]) begin
                                kcode = KEY_TABLE[i];
                        end
                end
                klines = s.keypad_sel_n ? 4'b1111 : kcode;
                kfire  = s.keypad_sel_n ? 1'b1 : ~p.fire2;
                jlines = s.joy_sel_n ? 4'b1111 : ~{p.up, p.down, p.left, p.right};
                jfire  = s.joy_sel_n ? 1'b1 : ~p.fire1;
                return {klines & jlines, kfire & jfire};
        endfunction

        always_comb begin
                kbd_model        = '0;
                kbd_model.digit  = digit_q;
                kbd_model.star   = star_q | (shift_q & digit_q[8]);
                kbd_model.number = minus_q | (shift_q & digit_q[3]);
                pad_model[0] = coleco_ctrl_pkg::pad_buttons_t'(joy_to_pad(swap ? joy_b : joy_a)
                                                               | kbd_model);
                pad_model[1] = coleco_ctrl_pkg::pad_buttons_t'(joy_to_pad(swap ? joy_a : joy_b)
                                                               | kbd_model);
                expected_ctrl[0] = port_model(pad_model[0], sel[0]);
                expected_ctrl[1] = port_model(pad_model[1], sel[1]);
        end

        // Latches take the event at the edge after it was driven
        always_ff @(posedge clk_sys or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        digit_q <= '0;
                        star_q  <= 1'b0;
                        minus_q <= 1'b0;
                        shift_q <= 1'b0;
                end else begin
                        digit_q <= digit_p;
                        star_q  <= star_p;
                        minus_q <= minus_p;
                        shift_q <= shift_p;
                end
        end

        // ============================================================
        // Checks
        // ============================================================
        task automatic report_mismatch(input string name, input logic [9:0] exp_v,
                                       input logic [9:0] act_v);
                $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp_v, act_v);
                $display("TESTS FAILED");
                $fatal(1, "output mismatch");
        endtask

        ctrl_match_a: assert property (
                @(posedge clk_sys) disable iff (!arst_n_i)
                ctrl_o == expected_ctrl
        ) else report_mismatch("ctrl_o", $sampled(expected_ctrl), $sampled(ctrl_o));

        // Idle joysticks and no held pad key leave both ports released
        idle_ports_a: assert property (
                @(posedge clk_sys) disable iff (!arst_n_i)
                (joy_a == '0 && joy_b == '0 && digit_q == '0 && !star_q && !minus_q)
                |-> ctrl_o == '1
        ) else report_mismatch("ctrl_o (idle)", '1, $sampled(ctrl_o));

        // ============================================================
        // Stimulus
        // ============================================================
        task automatic next_cycle();
                @(posedge clk_sys);
                #1;
        endtask

        function automatic logic [31:0] random_joy();
                // Thinned so several buttons are rarely held at once
                return $urandom & $urandom & $urandom;
        endfunction

        task automatic send_key(input logic [7:0] scan, input logic make, input logic ext);
                int i;

                ps2_key.pressed  = make;
                ps2_key.extended = ext;
                ps2_key.scan     = scan;
                ps2_key.toggle   = ~ps2_key.toggle;
                for (i = 0; i < 10; i++) begin
                        if (scan == SCAN_TOP[i] || scan == SCAN_KP[i]) begin
                                digit_p[i] = make;
                        end
                end
                if (scan == 8'h7C) star_p = make;
                if (scan == 8'h7B) minus_p = make;
                if (scan == 8'h12 || scan == 8'h59) shift_p = make;
        endtask

        task automatic key_event(input logic [7:0] scan, input logic make);
                send_key(scan, make, 1'b0);
                next_cycle();
                next_cycle();
        endtask

        initial begin
                #((RESET_CYCLES + TEST_CYCLES + MARGIN) * 10);
                $display("Watchdog expired before the stimulus finished");
                $display("TESTS FAILED");
                $fatal(1, "timeout");
        end

        initial begin
                logic [31:0] rnd;
                logic [7:0]  pick;
                int          i;
                int          idx;

                void'($urandom(32'ha27a_d445));
                clk_sys  = 1'b0;
                arst_n_i = 1'b0;
                ps2_key  = '0;
                joy_a    = '0;
                joy_b    = '0;
                swap     = 1'b0;
                sel      = '1;
                digit_p  = '0;
                star_p   = 1'b0;
                minus_p  = 1'b0;
                shift_p  = 1'b0;
                repeat (RESET_CYCLES) @(posedge clk_sys);
                #1 arst_n_i = 1'b1;

                // Idle ports under every strobe pattern
                for (i = 0; i < 16; i++) begin
                        sel = i[3:0];
                        next_cycle();
                end

                // Keypad segment, single buttons then random words
                sel = 4'b0101;
                for (i = 0; i < 14; i++) begin
                        joy_a = 32'd1 << BTN_BIT[i];
                        joy_b = 32'd1 << BTN_BIT[13 - i];
                        next_cycle();
                end
                joy_a = 32'd1 << 5;
                joy_b = '0;
                next_cycle();
                for (i = 0; i < N_PAD; i++) begin
                        joy_a = random_joy();
                        joy_b = random_joy();
                        next_cycle();
                end

                // Joystick segment alone, then both segments together
                sel = 4'b1010;
                for (i = 0; i < 5; i++) begin
                        joy_a = 32'd1 << i;
                        joy_b = 32'd1 << (4 - i);
                        next_cycle();
                end
                sel = 4'b0000;
                for (i = 0; i < N_BOTH; i++) begin
                        joy_a = random_joy();
                        joy_b = random_joy();
                        next_cycle();
                end

                // Player swap
                swap = 1'b1;
                for (i = 0; i < N_SWAP; i++) begin
                        rnd   = $urandom;
                        sel   = rnd[3:0];
                        joy_a = random_joy();
                        joy_b = random_joy();
                        next_cycle();
                end

                // Keyboard pad
                swap  = 1'b0;
                joy_a = '0;
                joy_b = '0;
                sel   = 4'b0101;
                key_event(8'h16, 1'b1);
                key_event(8'h16, 1'b0);
                key_event(8'h73, 1'b1);
                key_event(8'h73, 1'b0);
                key_event(8'h7C, 1'b1);
                key_event(8'h7C, 1'b0);
                key_event(8'h12, 1'b1);
                key_event(8'h3E, 1'b1);
                key_event(8'h3E, 1'b0);
                key_event(8'h12, 1'b0);
                key_event(8'h59, 1'b1);
                key_event(8'h26, 1'b1);
                key_event(8'h26, 1'b0);
                key_event(8'h59, 1'b0);
                key_event(8'h7B, 1'b1);
                key_event(8'h7B, 1'b0);
                next_cycle();

                // Everything mixed
                for (i = 0; i < N_MIX; i++) begin
                        rnd   = $urandom;
                        swap  = rnd[0];
                        sel   = rnd[4:1];
                        joy_a = random_joy();
                        joy_b = random_joy();
                        if (rnd[7:5] < 3'd2) begin
                                idx = int'(rnd[31:16]) % 25;
                                if (idx < 10) pick = SCAN_TOP[idx];
                                else if (idx < 20) pick = SCAN_KP[idx - 10];
                                else pick = SCAN_EXTRA[idx - 20];
                                send_key(pick, rnd[8], rnd[9]);
                        end
                        next_cycle();
                end
                next_cycle();

                $display("TESTS PASSED");
                $finish;
        end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
coleco_ctrl_pkg.sv
ps2_keypad_emu.sv
keypad_encoder.sv
controller_ports.sv
coleco_ctrl_top.sv
tb_coleco_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
        --top-module tb_coleco_ctrl -Mdir obj_dir \
        && ./obj_dir/Vtb_coleco_ctrl 2>&1 | tee sim.log
grep -q "TESTS PASSED" sim.log && echo "simulation passed" \
        || { echo "simulation failed"; exit 1; }
